/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= nx_node_tb
FILELIST  ?= nx_node.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* nx_node.f */
source/nx_pkg.sv
source/nx_fifo.sv
source/nx_msg_decoder.sv
source/nx_instr_store.sv
source/nx_pc.sv
source/nx_node_fsm.sv
source/nx_node_core.sv
source/nx_io_map.sv
source/nx_node.sv
verif/nx_node_properties.sv
verif/nx_node_tb.sv

/* source/nx_fifo.sv */
`timescale 1ns/1ps

module nx_fifo #(
      parameter int DEPTH = 4 // Power of two so pointers wrap naturally
) (
      input  logic                clk_i
    , input  logic                rst_i
    // Write side
    , input  nx_pkg::nx_message_t wr_data_i
    , input  logic                wr_push_i
    // Read side
    , output nx_pkg::nx_message_t rd_data_o
    , input  logic                rd_pop_i
    // Status
    , output logic                empty_o
    , output logic                full_o
);

nx_pkg::nx_message_t        mem [DEPTH];
logic [$clog2(DEPTH)-1:0]   wr_ptr, rd_ptr;
logic [$clog2(DEPTH):0]     level;   // One extra bit to tell full from empty
logic                       do_push, do_pop;

assign do_push   = wr_push_i && !full_o;  // Push into a full FIFO is lost
assign do_pop    = rd_pop_i && !empty_o;
assign empty_o   = (level == '0);
assign full_o    = (level == DEPTH);
assign rd_data_o = mem[rd_ptr];           // Head is always visible

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        level  <= '0;
    end else begin
        if (do_push) wr_ptr <= wr_ptr + 1'b1;
        if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
        // Simultaneous push and pop leaves level alone
        if (do_push && !do_pop)      level <= level + 1'b1;
        else if (do_pop && !do_push) level <= level - 1'b1;
    end
end

always_ff @(posedge clk_i) begin
    if (do_push) mem[wr_ptr] <= wr_data_i;
end

endmodule : nx_fifo

/* source/nx_instr_store.sv */
`timescale 1ns/1ps

module nx_instr_store (
      input  logic              clk_i
    , input  logic              rst_i
    , input  logic              load_i
    , input  nx_pkg::nx_instr_t load_data_i
    , input  nx_pkg::nx_pc_t    rd_pc_i
    , output nx_pkg::nx_instr_t instr_o
    , output nx_pkg::nx_count_t count_o
);

nx_pkg::nx_instr_t mem [nx_pkg::NX_PROG_DEPTH];
nx_pkg::nx_count_t count_q;  // Also the write slot
logic              wr_en;

// Once full, further loads are ignored
assign wr_en   = load_i && (count_q != nx_pkg::NX_PROG_DEPTH);
assign instr_o = mem[rd_pc_i];
assign count_o = count_q;

always_ff @(posedge clk_i) begin
    if (rst_i)      count_q <= '0;
    else if (wr_en) count_q <= count_q + 1'b1;
end

always_ff @(posedge clk_i) begin
    if (wr_en) mem[count_q[nx_pkg::NX_PC_W-1:0]] <= load_data_i;
end

endmodule : nx_instr_store

/* source/nx_io_map.sv */
`timescale 1ns/1ps

module nx_io_map (
      input  logic                clk_i
    , input  logic                rst_i
    // Table writes
    , input  nx_pkg::nx_idx_t     map_idx_i
    , input  nx_pkg::nx_row_t     map_row_i
    , input  nx_pkg::nx_col_t     map_col_i
    , input  nx_pkg::nx_idx_t     map_tgt_idx_i
    , input  logic                map_tgt_seq_i
    , input  logic                map_valid_i
    // Results from the core
    , input  logic                res_valid_i
    , input  nx_pkg::nx_idx_t     res_idx_i
    , input  logic                res_state_i
    // Outgoing signal messages
    , output nx_pkg::nx_message_t out_msg_o
    , output logic                out_valid_o
);

logic [nx_pkg::NX_IO-1:0] ent_valid_q;
nx_pkg::nx_row_t          ent_row_q  [nx_pkg::NX_IO];
nx_pkg::nx_col_t          ent_col_q  [nx_pkg::NX_IO];
nx_pkg::nx_idx_t          ent_idx_q  [nx_pkg::NX_IO];
logic                     ent_seq_q  [nx_pkg::NX_IO];
nx_pkg::nx_message_t      msg_d;

always_ff @(posedge clk_i) begin
    if (rst_i)            ent_valid_q            <= '0;
    else if (map_valid_i) ent_valid_q[map_idx_i] <= 1'b1;
end

always_ff @(posedge clk_i) begin
    if (map_valid_i) begin
        ent_row_q[map_idx_i] <= map_row_i;
        ent_col_q[map_idx_i] <= map_col_i;
        ent_idx_q[map_idx_i] <= map_tgt_idx_i;
        ent_seq_q[map_idx_i] <= map_tgt_seq_i;
    end
end

// Signal message to the mapped target, unused bits zero
always_comb begin
    msg_d = '0;
    msg_d[nx_pkg::NX_ROW_LSB +: nx_pkg::NX_ROW_W] = ent_row_q[res_idx_i];
    msg_d[nx_pkg::NX_COL_LSB +: nx_pkg::NX_COL_W] = ent_col_q[res_idx_i];
    msg_d[nx_pkg::NX_CMD_LSB +: nx_pkg::NX_CMD_W] = nx_pkg::NX_CMD_SIG_STATE;
    msg_d[nx_pkg::NX_IDX_LSB +: nx_pkg::NX_IO_W]  = ent_idx_q[res_idx_i];
    msg_d[nx_pkg::NX_SIG_SEQ_BIT]                 = ent_seq_q[res_idx_i];
    msg_d[nx_pkg::NX_SIG_STATE_BIT]               = res_state_i;
end

always_ff @(posedge clk_i) begin
    if (rst_i) out_valid_o <= 1'b0;
    else       out_valid_o <= res_valid_i && ent_valid_q[res_idx_i]; // Unmapped is dropped
end

always_ff @(posedge clk_i) begin
    if (res_valid_i) out_msg_o <= msg_d;
end

endmodule : nx_io_map

/* source/nx_msg_decoder.sv */
`timescale 1ns/1ps

module nx_msg_decoder (
      input  logic                clk_i
    , input  logic                rst_i
    , output logic                idle_o
    // Inbound stream
    , input  nx_pkg::nx_message_t msg_data_i
    , input  logic                msg_valid_i
    , output logic                msg_ready_o
    // Output mapping
    , output nx_pkg::nx_idx_t     map_idx_o
    , output nx_pkg::nx_row_t     map_row_o
    , output nx_pkg::nx_col_t     map_col_o
    , output nx_pkg::nx_idx_t     map_tgt_idx_o
    , output logic                map_tgt_seq_o
    , output logic                map_valid_o
    // Signal update
    , output nx_pkg::nx_idx_t     sig_idx_o
    , output logic                sig_seq_o
    , output logic                sig_state_o
    , output logic                sig_valid_o
    // Instruction load
    , output nx_pkg::nx_instr_t   instr_data_o
    , output logic                instr_valid_o
);

logic                fifo_empty, fifo_full;
nx_pkg::nx_message_t head;
nx_pkg::nx_command_t head_cmd;
logic                pop_q;    // Head taken last cycle, popping now
logic                take;
logic                instr_hit, map_hit, sig_hit;

nx_fifo #(
      .DEPTH(4)
) i_fifo (
      .clk_i    (clk_i)
    , .rst_i    (rst_i)
    , .wr_data_i(msg_data_i)
    , .wr_push_i(msg_valid_i && msg_ready_o)
    , .rd_data_o(head)
    , .rd_pop_i (pop_q)
    , .empty_o  (fifo_empty)
    , .full_o   (fifo_full)
);

assign msg_ready_o = !fifo_full;
assign head_cmd    = nx_pkg::nx_command_t'(head[nx_pkg::NX_CMD_LSB +: nx_pkg::NX_CMD_W]);
assign take        = !fifo_empty && !pop_q; // Every other cycle at most

// Nothing buffered, nothing arriving, nothing in flight
assign idle_o = fifo_empty && !msg_valid_i && !pop_q
             && !map_valid_o && !sig_valid_o && !instr_valid_o;

always_comb begin
    instr_hit = 1'b0;
    map_hit   = 1'b0;
    sig_hit   = 1'b0;
    case (head_cmd)
        nx_pkg::NX_CMD_LOAD_INSTR: instr_hit = take;
        nx_pkg::NX_CMD_MAP_OUTPUT: map_hit   = take;
        nx_pkg::NX_CMD_SIG_STATE:  sig_hit   = take;
        nx_pkg::NX_CMD_UNUSED:     ;                 // Popped and dropped
        default:                   ;
    endcase
end

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        pop_q         <= 1'b0;
        instr_valid_o <= 1'b0;
        map_valid_o   <= 1'b0;
        sig_valid_o   <= 1'b0;
    end else begin
        pop_q         <= take;
        instr_valid_o <= instr_hit; // Single-cycle strobes
        map_valid_o   <= map_hit;
        sig_valid_o   <= sig_hit;
    end
end

// Field capture, qualified by the strobes downstream
always_ff @(posedge clk_i) begin
    if (take) begin
        instr_data_o  <= head[nx_pkg::NX_INSTR_W-1:0];
        map_idx_o     <= head[nx_pkg::NX_IDX_LSB +: nx_pkg::NX_IO_W];
        map_row_o     <= head[nx_pkg::NX_MAP_ROW_LSB +: nx_pkg::NX_ROW_W];
        map_col_o     <= head[nx_pkg::NX_MAP_COL_LSB +: nx_pkg::NX_COL_W];
        map_tgt_idx_o <= head[nx_pkg::NX_MAP_TIDX_LSB +: nx_pkg::NX_IO_W];
        map_tgt_seq_o <= head[nx_pkg::NX_MAP_TSEQ_BIT];
        sig_idx_o     <= head[nx_pkg::NX_IDX_LSB +: nx_pkg::NX_IO_W];
        sig_seq_o     <= head[nx_pkg::NX_SIG_SEQ_BIT];
        sig_state_o   <= head[nx_pkg::NX_SIG_STATE_BIT];
    end
end

endmodule : nx_msg_decoder

/* source/nx_node.sv */
`timescale 1ns/1ps

module nx_node (
      input  logic                clk_i
    , input  logic                rst_i
    // Inbound stream
    , input  nx_pkg::nx_message_t msg_data_i
    , input  logic                msg_valid_i
    , output logic                msg_ready_o
    // Outbound strobe, no back-pressure
    , output nx_pkg::nx_message_t out_msg_o
    , output logic                out_valid_o
    , output logic                idle_o
);

nx_pkg::nx_idx_t   map_idx, map_tgt_idx, sig_idx, res_idx;
nx_pkg::nx_row_t   map_row;
nx_pkg::nx_col_t   map_col;
logic              map_tgt_seq, map_valid;
logic              sig_seq, sig_state, sig_valid;
nx_pkg::nx_instr_t instr_data, instr;
logic              instr_valid;
logic              dec_idle, run_req, run_start, step, pc_clear, busy, last;
nx_pkg::nx_pc_t    pc;
nx_pkg::nx_count_t count;
logic              res_valid, res_state;

// Quiet only when no message, run or request is anywhere in flight
assign idle_o = dec_idle && !busy && !run_req;

nx_msg_decoder i_decoder (
      .clk_i(clk_i), .rst_i(rst_i), .idle_o(dec_idle)
    , .msg_data_i(msg_data_i), .msg_valid_i(msg_valid_i), .msg_ready_o(msg_ready_o)
    , .map_idx_o(map_idx), .map_row_o(map_row), .map_col_o(map_col)
    , .map_tgt_idx_o(map_tgt_idx), .map_tgt_seq_o(map_tgt_seq), .map_valid_o(map_valid)
    , .sig_idx_o(sig_idx), .sig_seq_o(sig_seq), .sig_state_o(sig_state)
    , .sig_valid_o(sig_valid)
    , .instr_data_o(instr_data), .instr_valid_o(instr_valid)
);

nx_node_fsm i_fsm (
      .clk_i(clk_i), .rst_i(rst_i)
    , .run_req_i(run_req), .dec_idle_i(dec_idle), .count_i(count), .last_i(last)
    , .run_start_o(run_start), .step_o(step), .pc_clear_o(pc_clear), .busy_o(busy)
);

nx_pc i_pc (
      .clk_i(clk_i), .rst_i(rst_i), .clear_i(pc_clear), .step_i(step)
    , .count_i(count), .pc_o(pc), .last_o(last)
);

nx_instr_store i_store (
      .clk_i(clk_i), .rst_i(rst_i)
    , .load_i(instr_valid), .load_data_i(instr_data)
    , .rd_pc_i(pc), .instr_o(instr), .count_o(count)
);

// Core executes whenever the pc steps
nx_node_core i_core (
      .clk_i(clk_i), .rst_i(rst_i)
    , .sig_idx_i(sig_idx), .sig_seq_i(sig_seq), .sig_state_i(sig_state)
    , .sig_valid_i(sig_valid)
    , .run_start_i(run_start), .exec_i(step), .instr_i(instr), .run_req_o(run_req)
    , .res_valid_o(res_valid), .res_idx_o(res_idx), .res_state_o(res_state)
);

nx_io_map i_io_map (
      .clk_i(clk_i), .rst_i(rst_i)
    , .map_idx_i(map_idx), .map_row_i(map_row), .map_col_i(map_col)
    , .map_tgt_idx_i(map_tgt_idx), .map_tgt_seq_i(map_tgt_seq), .map_valid_i(map_valid)
    , .res_valid_i(res_valid), .res_idx_i(res_idx), .res_state_i(res_state)
    , .out_msg_o(out_msg_o), .out_valid_o(out_valid_o)
);

endmodule : nx_node

/* source/nx_node_core.sv */
`timescale 1ns/1ps

module nx_node_core (
      input  logic              clk_i
    , input  logic              rst_i
    // Signal updates
    , input  nx_pkg::nx_idx_t   sig_idx_i
    , input  logic              sig_seq_i
    , input  logic              sig_state_i
    , input  logic              sig_valid_i
    // Execution control
    , input  logic              run_start_i
    , input  logic              exec_i
    , input  nx_pkg::nx_instr_t instr_i
    , output logic              run_req_o
    // Results towards the output map
    , output logic              res_valid_o
    , output nx_pkg::nx_idx_t   res_idx_o
    , output logic              res_state_o
);

logic [nx_pkg::NX_IO-1:0]    inputs_q;
logic [nx_pkg::NX_IO-1:0]    staged_q;      // Sequential values waiting for a run
logic [nx_pkg::NX_IO-1:0]    staged_set_q;  // Which staged bits are fresh
logic [nx_pkg::NX_IO-1:0]    regs_q;
logic                        pending_q;
nx_pkg::nx_op_t              op;
logic [nx_pkg::NX_SRC_W-1:0] src_a, src_b;
nx_pkg::nx_idx_t             dst;
logic                        val_a, val_b, result;

// Instruction decode
assign op    = nx_pkg::nx_op_t'(instr_i[nx_pkg::NX_OP_LSB +: nx_pkg::NX_OP_W]);
assign src_a = instr_i[nx_pkg::NX_SRC_A_LSB +: nx_pkg::NX_SRC_W];
assign src_b = instr_i[nx_pkg::NX_SRC_B_LSB +: nx_pkg::NX_SRC_W];
assign dst   = instr_i[nx_pkg::NX_DST_LSB +: nx_pkg::NX_IO_W];

// Upper source bit selects working registers over inputs
assign val_a = src_a[nx_pkg::NX_IO_W] ? regs_q[src_a[nx_pkg::NX_IO_W-1:0]]
                                      : inputs_q[src_a[nx_pkg::NX_IO_W-1:0]];
assign val_b = src_b[nx_pkg::NX_IO_W] ? regs_q[src_b[nx_pkg::NX_IO_W-1:0]]
                                      : inputs_q[src_b[nx_pkg::NX_IO_W-1:0]];

always_comb begin
    case (op)
        nx_pkg::NX_OP_AND:    result = val_a & val_b;
        nx_pkg::NX_OP_OR:     result = val_a | val_b;
        nx_pkg::NX_OP_XOR:    result = val_a ^ val_b;
        nx_pkg::NX_OP_NAND:   result = ~(val_a & val_b);
        nx_pkg::NX_OP_NOR:    result = ~(val_a | val_b);
        nx_pkg::NX_OP_XNOR:   result = ~(val_a ^ val_b);
        nx_pkg::NX_OP_INV_A:  result = ~val_a;  // B ignored
        default:              result = val_a;   // COPY_A
    endcase
end

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        inputs_q     <= '0;
        staged_set_q <= '0;
        pending_q    <= 1'b0;
    end else begin
        if (run_start_i) begin
            // Fresh staged bits replace their inputs
            inputs_q     <= (inputs_q & ~staged_set_q) | (staged_q & staged_set_q);
            staged_set_q <= '0;
            pending_q    <= 1'b0;
        end
        if (sig_valid_i && sig_seq_i) begin
            staged_set_q[sig_idx_i] <= 1'b1;
        end else if (sig_valid_i) begin
            inputs_q[sig_idx_i] <= sig_state_i;
            pending_q           <= 1'b1;  // Ask for a run
        end
    end
end

always_ff @(posedge clk_i) begin
    if (sig_valid_i && sig_seq_i) staged_q[sig_idx_i] <= sig_state_i;
end

always_ff @(posedge clk_i) begin
    if (rst_i)       regs_q      <= '0;
    else if (exec_i) regs_q[dst] <= result;
end

assign run_req_o = pending_q;

// Result leaves in the executing cycle, the output map registers it
assign res_valid_o = exec_i && instr_i[nx_pkg::NX_OUT_BIT];
assign res_idx_o   = dst;
assign res_state_o = result;

endmodule : nx_node_core

/* source/nx_node_fsm.sv */
`timescale 1ns/1ps

module nx_node_fsm (
      input  logic              clk_i
    , input  logic              rst_i
    , input  logic              run_req_i
    , input  logic              dec_idle_i
    , input  nx_pkg::nx_count_t count_i
    , input  logic              last_i
    , output logic              run_start_o
    , output logic              step_o
    , output logic              pc_clear_o
    , output logic              busy_o
);

nx_pkg::nx_node_state_t state_q, state_d;

always_comb begin
    state_d = state_q;
    case (state_q)
        nx_pkg::NX_ST_IDLE: begin
            // Wait for decoder to drain so the program is settled
            if (run_req_i && dec_idle_i && (count_i != '0)) begin
                state_d = nx_pkg::NX_ST_START;
            end
        end
        nx_pkg::NX_ST_START: state_d = nx_pkg::NX_ST_RUN;
        nx_pkg::NX_ST_RUN:   if (last_i) state_d = nx_pkg::NX_ST_DONE;
        nx_pkg::NX_ST_DONE:  state_d = nx_pkg::NX_ST_IDLE;
        default:             state_d = nx_pkg::NX_ST_IDLE;
    endcase
end

always_ff @(posedge clk_i) begin
    if (rst_i) state_q <= nx_pkg::NX_ST_IDLE;
    else       state_q <= state_d;
end

assign run_start_o = (state_q == nx_pkg::NX_ST_START); // Latch staged inputs
assign pc_clear_o  = (state_q == nx_pkg::NX_ST_START); // pc is 0 on first RUN cycle
assign step_o      = (state_q == nx_pkg::NX_ST_RUN);   // One instruction per cycle
assign busy_o      = (state_q != nx_pkg::NX_ST_IDLE);

endmodule : nx_node_fsm

/* source/nx_pc.sv */
`timescale 1ns/1ps

module nx_pc (
      input  logic              clk_i
    , input  logic              rst_i
    , input  logic              clear_i
    , input  logic              step_i
    , input  nx_pkg::nx_count_t count_i
    , output nx_pkg::nx_pc_t    pc_o
    , output logic              last_o
);

nx_pkg::nx_pc_t pc_q;

always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
        pc_q <= '0;
    end else if (step_i) begin
        pc_q <= pc_q + 1'b1;  // Wraps past slot 15 on a full program
    end
end

assign pc_o = pc_q;

// Compare at count width so a count of 16 still works
assign last_o = ({1'b0, pc_q} == count_i - 1'b1);

endmodule : nx_pc

/* source/nx_pkg.sv */
package nx_pkg;

    // Message and field widths
    localparam int NX_ROW_W      = 4;
    localparam int NX_COL_W      = 4;
    localparam int NX_CMD_W      = 2;
    localparam int NX_MSG_W      = 32;
    localparam int NX_INSTR_W    = 15;
    localparam int NX_IO         = 8;  // Inputs, outputs and working registers
    localparam int NX_IO_W       = 3;
    localparam int NX_PROG_DEPTH = 16; // Instruction slots
    localparam int NX_PC_W       = 4;
    localparam int NX_COUNT_W    = 5;  // Holds 0 to 16

    // Header positions
    localparam int NX_ROW_LSB = 28;
    localparam int NX_COL_LSB = 24;
    localparam int NX_CMD_LSB = 22;
    localparam int NX_IDX_LSB = 19; // Map source index or signal input index

    // Map payload positions
    localparam int NX_MAP_ROW_LSB  = 15;
    localparam int NX_MAP_COL_LSB  = 11;
    localparam int NX_MAP_TIDX_LSB = 8;
    localparam int NX_MAP_TSEQ_BIT = 7;

    // Signal payload positions
    localparam int NX_SIG_SEQ_BIT   = 18;
    localparam int NX_SIG_STATE_BIT = 17;

    // Instruction fields
    localparam int NX_OP_LSB    = 12;
    localparam int NX_OP_W      = 3;
    localparam int NX_SRC_A_LSB = 8;
    localparam int NX_SRC_B_LSB = 4;
    localparam int NX_SRC_W     = 4;  // Top bit picks register bank
    localparam int NX_DST_LSB   = 1;
    localparam int NX_OUT_BIT   = 0;

    typedef logic [NX_MSG_W-1:0]   nx_message_t;
    typedef logic [NX_INSTR_W-1:0] nx_instr_t;
    typedef logic [NX_ROW_W-1:0]   nx_row_t;
    typedef logic [NX_COL_W-1:0]   nx_col_t;
    typedef logic [NX_IO_W-1:0]    nx_idx_t;
    typedef logic [NX_PC_W-1:0]    nx_pc_t;
    typedef logic [NX_COUNT_W-1:0] nx_count_t;

    typedef enum logic [NX_CMD_W-1:0] {
        NX_CMD_LOAD_INSTR = 2'd0,
        NX_CMD_MAP_OUTPUT = 2'd1,
        NX_CMD_SIG_STATE  = 2'd2,
        NX_CMD_UNUSED     = 2'd3
    } nx_command_t;

    typedef enum logic [NX_OP_W-1:0] {
        NX_OP_AND, NX_OP_OR, NX_OP_XOR, NX_OP_NAND,
        NX_OP_NOR, NX_OP_XNOR, NX_OP_INV_A, NX_OP_COPY_A
    } nx_op_t;

    typedef enum logic [1:0] {
        NX_ST_IDLE, NX_ST_START, NX_ST_RUN, NX_ST_DONE
    } nx_node_state_t;

endpackage : nx_pkg

/* verif/nx_node_properties.sv */
`timescale 1ns/1ps

module nx_node_properties (
      input logic              clk_i
    , input logic              rst_i
    , input logic              out_valid_i
    , input logic              step_i       // High in RUN
    , input logic              run_start_i
    , input logic              fifo_empty_i
    , input nx_pkg::nx_pc_t    pc_i
    , input nx_pkg::nx_count_t count_i
);

// Outgoing strobe trails an executing cycle by one
out_after_run: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_i |-> $past(step_i))
    else $error("out_valid_o without an executing cycle before it");

// Program and inputs settled before a run begins
start_on_empty: assert property (@(posedge clk_i) disable iff (rst_i)
    run_start_i |-> fifo_empty_i)
    else $error("run_start while inbound FIFO holds messages");

// pc reaches count at most, in the DONE cycle
pc_in_range: assert property (@(posedge clk_i) disable iff (rst_i)
    {1'b0, pc_i} <= count_i)
    else $error("pc beyond instruction count");

endmodule : nx_node_properties

bind nx_node nx_node_properties i_nx_node_properties (
      .clk_i       (clk_i)
    , .rst_i       (rst_i)
    , .out_valid_i (out_valid_o)
    , .step_i      (step)
    , .run_start_i (run_start)
    , .fifo_empty_i(i_decoder.fifo_empty)
    , .pc_i        (pc)
    , .count_i     (count)
);

/* verif/nx_node_tb.sv */
`timescale 1ns/1ps

module nx_node_tb;

localparam int CLK_HALF      = 50;   // 100 ns clock
localparam int DRIVE_DELAY   = 1;    // Inputs move just after the rising edge
localparam int READY_TIMEOUT = 200;  // Cycles
localparam int IDLE_TIMEOUT  = 500;

logic                clk;
logic                rst;
nx_pkg::nx_message_t msg_data;
logic                msg_valid;
logic                msg_ready;
nx_pkg::nx_message_t out_msg;
logic                out_valid;
logic                idle;

nx_pkg::nx_message_t expected_q [$];  // Outgoing messages still owed, in order

nx_node i_nx_node (
      .clk_i      (clk)
    , .rst_i      (rst)
    , .msg_data_i (msg_data)
    , .msg_valid_i(msg_valid)
    , .msg_ready_o(msg_ready)
    , .out_msg_o  (out_msg)
    , .out_valid_o(out_valid)
    , .idle_o     (idle)
);

initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
end

// Print the reason, then the verdict, then stop
task automatic abort_run(input string reason);
    $display("%0s", reason);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Stopped at first error");
endtask

// Called just after an edge, returns just after the accepting edge
task automatic send_message(input nx_pkg::nx_message_t msg);
    int waited;
    waited    = 0;
    msg_data  = msg;
    msg_valid = 1'b1;
    @(negedge clk);  // Ready settles well before the next edge
    while (!msg_ready && waited < READY_TIMEOUT) begin
        waited++;
        @(negedge clk);
    end
    if (!msg_ready) begin
        abort_run("Timed out waiting for msg_ready_o");
    end else begin
        @(posedge clk);  // Transfer happens here
        #DRIVE_DELAY;
        msg_valid = 1'b0;
    end
endtask

task automatic wait_idle();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!idle && waited < IDLE_TIMEOUT) begin
        waited++;
        @(negedge clk);
    end
    if (!idle) begin
        abort_run("Timed out waiting for idle_o");
    end else begin
        @(posedge clk);
        #DRIVE_DELAY;
    end
endtask

// One token per step: comment, send, wait or expect
task automatic play_vectors(input int fd);
    logic [8*16-1:0]     kind;
    logic [8*120-1:0]    rest;
    nx_pkg::nx_message_t value;
    int                  n;
    while ($fscanf(fd, "%s", kind) == 1) begin
        case (kind)
            "#": n = $fgets(rest, fd);  // Skip rest of comment line
            "S": begin
                n = $fscanf(fd, "%h", value);
                assert (n == 1) else abort_run("Send line has no hex message");
                send_message(value);
            end
            "W": wait_idle();
            "E": begin
                n = $fscanf(fd, "%h", value);
                assert (n == 1) else abort_run("Expect line has no hex value");
                expected_q.push_back(value);
            end
            default: abort_run($sformatf("Unknown vector kind %0s", kind));
        endcase
    end
endtask

// Compare each outgoing strobe while the bus is stable
always @(negedge clk) begin
    nx_pkg::nx_message_t exp;
    if (!rst && out_valid) begin
        assert (expected_q.size() > 0)
            else abort_run("Outgoing message arrived when none was expected");
        exp = expected_q.pop_front();
        assert (out_msg == exp)
            else abort_run($sformatf("Fail out_msg_o got %h expected %h", out_msg, exp));
    end
end

initial begin
    int fd;
    rst       = 1'b1;
    msg_data  = '0;
    msg_valid = 1'b0;
    repeat (5) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;
    @(negedge clk);
    assert (idle && msg_ready && !out_valid)
        else abort_run("Node is not idle and ready after reset");
    @(posedge clk);
    #DRIVE_DELAY;

    fd = $fopen("verif/nx_node_vectors.txt", "r");
    assert (fd != 0) else abort_run("Cannot open verif/nx_node_vectors.txt");
    play_vectors(fd);
    $fclose(fd);

    repeat (4) @(negedge clk);  // Quiet tail, catches stray messages
    if (expected_q.size() != 0) begin
        abort_run($sformatf("%0d expected messages never arrived", expected_q.size()));
    end else begin
        $display("TEST RESULT: PASS");
        $finish;
    end
end

endmodule : nx_node_tb

/* verif/nx_node_vectors.txt */
# kind S sends a message, W waits for idle, E queues an expected outgoing message
# S and E carry a 32-bit hex value, W has none
# program: AND in0 in1 to r0, XOR in2 r0 to r1, INV_A in3 to r2, COPY_A r1 to r3
S 00000011
S 00002283
S 00006305
S 00007907
# map out0, out1 and out3, out2 stays unmapped
S 00409500
S 0049A680
S 005B8A00
W
# in0 high
E 12A80000
E 34B40000
E 71900000
S 00820000
W
# in1 high
E 12AA0000
E 34B60000
E 71920000
S 008A0000
W
# sequential in2 high stages only, in1 low then runs
S 00960000
W
E 12A80000
E 34B60000
E 71920000
S 00880000
W
# eight updates back to back through a full FIFO
E 12AA0000
E 34B40000
E 71900000
S 00800000
S 008A0000
S 00900000
S 009A0000
S 00820000
S 00920000
S 00880000
S 008A0000
W
# command 3 is dropped, then in0 low
S 00C07001
W
E 12A80000
E 34B60000
E 71920000
S 00800000
W
